// File: verif/div_rs_cases.txt
# dv pc rd op s1 s2 r1 r2  alu_v tag mul_v tag div_v tag load_v tag  exception mret
# expected: full issue_valid pc rd op src1 src2 (issue fields checked when issue_valid is 1)
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00001000 10 3 21 22 1 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00001000 10 3 21 22
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00001004 11 4 31 32 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  1 31 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00001004 11 4 31 32
1 00001008 12 5 41 42 1 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 1 42 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00001008 12 5 41 42
1 0000100c 13 6 51 52 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 1 51 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 0000100c 13 6 51 52
1 00001010 14 7 61 62 1 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 1 62  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00001010 14 7 61 62
1 00001014 15 8 71 72 0 1  1 71 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00001014 15 8 71 72
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00002000 20 1 81 82 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00002004 21 2 83 84 1 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00002004 21 2 83 84
0 00000000 00 0 00 00 0 0  1 81 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00002000 20 1 81 82
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00003000 30 9 90 a0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00003004 31 9 91 a0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00003008 32 9 92 a0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 0000300c 33 9 93 a0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00003010 34 9 94 a0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00003014 35 9 95 a0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00003018 36 9 96 a0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 0000301c 37 9 97 a0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00003020 38 a b0 b1 1 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  1 90 1 91 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00003000 30 9 90 a0
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00003004 31 9 91 a0
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00003020 38 a b0 b1
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 1  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  1 92 1 93 1 94 1 95  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00004000 40 b c1 c2 1 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00004000 40 b c1 c2
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005000 50 c d0 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005004 51 c d1 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005008 52 c d2 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 0000500c 53 c d3 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005010 54 c d4 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005014 55 c d5 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005018 56 c d6 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 0000501c 57 c d7 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005020 58 c d8 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005024 59 c d9 e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005028 5a c da e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 0000502c 5b c db e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005030 5c c dc e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005034 5d c dd e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00005038 5e c de e0 0 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 0000503c 5f c df e0 0 1  0 00 0 00 0 00 0 00  0 0  1 0 00000000 00 0 00 00
1 00005040 60 d f0 f1 1 1  0 00 0 00 0 00 0 00  0 0  1 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  1 d0 0 00 0 00 0 00  0 0  1 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  1 1 00005000 50 c d0 e0
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  1 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  1 d1 1 d2 1 d3 1 d4  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
1 00006000 70 e 11 12 1 1  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 1 00006000 70 e 11 12
0 00000000 00 0 00 00 0 0  0 00 0 00 0 00 0 00  0 0  0 0 00000000 00 0 00 00

// File: div_rs.f
hw/div_rs_pkg.sv
hw/div_rs_ctrl.sv
hw/rs_payload_store.sv
hw/rs_wakeup.sv
hw/rs_issue_select.sv
hw/div_rs.sv
verif/div_rs_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the div_rs testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --top-module div_rs_tb -f div_rs.f -o div_rs_sim

./obj_dir/div_rs_sim 2>&1 | tee "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished, see $LOG"
exit 0

// File: verif/div_rs_tb.sv
`timescale 1ns/1ns

module div_rs_tb;
    import div_rs_pkg::*;

    localparam int    CLK_PERIOD = 100;
    localparam int    NUM_FIELDS = 25;
    localparam string CASE_FILE  = "verif/div_rs_cases.txt";

    logic      clk = 1'b0;
    logic      rst;
    logic      dispatch_valid;
    pc_t       dispatch_pc;
    phys_tag_t dispatch_rd;
    div_op_t   dispatch_op;
    phys_tag_t dispatch_src1;
    phys_tag_t dispatch_src2;
    logic      dispatch_src1_ready;
    logic      dispatch_src2_ready;
    logic      alu_valid;
    phys_tag_t alu_tag;
    logic      mul_valid;
    phys_tag_t mul_tag;
    logic      div_valid;
    phys_tag_t div_tag;
    logic      load_valid;
    phys_tag_t load_tag;
    logic      exception;
    logic      mret;
    logic      full;
    logic      issue_valid;
    pc_t       issue_pc;
    phys_tag_t issue_rd;
    div_op_t   issue_op;
    phys_tag_t issue_src1;
    phys_tag_t issue_src2;

    logic      exp_full;
    logic      exp_issue_valid;
    pc_t       exp_pc;
    phys_tag_t exp_rd;
    div_op_t   exp_op;
    phys_tag_t exp_src1;
    phys_tag_t exp_src2;

    string     case_lines [$];  // one entry per cycle
    int        n_cases         = 0;
    int        mismatch_errors = 0;
    int        other_errors    = 0;

    div_rs i_dut (
        .clk                 (clk),
        .rst                 (rst),
        .dispatch_valid      (dispatch_valid),
        .dispatch_pc         (dispatch_pc),
        .dispatch_rd         (dispatch_rd),
        .dispatch_op         (dispatch_op),
        .dispatch_src1       (dispatch_src1),
        .dispatch_src2       (dispatch_src2),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src2_ready (dispatch_src2_ready),
        .alu_valid           (alu_valid),
        .alu_tag             (alu_tag),
        .mul_valid           (mul_valid),
        .mul_tag             (mul_tag),
        .div_valid           (div_valid),
        .div_tag             (div_tag),
        .load_valid          (load_valid),
        .load_tag            (load_tag),
        .exception           (exception),
        .mret                (mret),
        .full                (full),
        .issue_valid         (issue_valid),
        .issue_pc            (issue_pc),
        .issue_rd            (issue_rd),
        .issue_op            (issue_op),
        .issue_src1          (issue_src1),
        .issue_src2          (issue_src2)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic drive_idle();
        dispatch_valid      = 1'b0;
        dispatch_pc         = '0;
        dispatch_rd         = '0;
        dispatch_op         = '0;
        dispatch_src1       = '0;
        dispatch_src2       = '0;
        dispatch_src1_ready = 1'b0;
        dispatch_src2_ready = 1'b0;
        alu_valid           = 1'b0;
        alu_tag             = '0;
        mul_valid           = 1'b0;
        mul_tag             = '0;
        div_valid           = 1'b0;
        div_tag             = '0;
        load_valid          = 1'b0;
        load_tag            = '0;
        exception           = 1'b0;
        mret                = 1'b0;
    endtask

    // keeps every line that is not blank and not a comment
    task automatic load_cases(output bit ok);
        int    fd;
        string line;
        ok = 1'b0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open case file %s", CASE_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() > 2 && line.getc(0) != "#") case_lines.push_back(line);
        end
        $fclose(fd);
        if (case_lines.size() == 0) begin
            $display("case file %s holds no cases", CASE_FILE);
            other_errors++;
        end else begin
            ok = 1'b1;
        end
    endtask

    // 18 input fields, then 7 expected outputs
    task automatic apply_case(input int num, output bit ok);
        int fields;
        fields = $sscanf(case_lines[num],
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            dispatch_valid, dispatch_pc, dispatch_rd, dispatch_op,
            dispatch_src1, dispatch_src2, dispatch_src1_ready, dispatch_src2_ready,
            alu_valid, alu_tag, mul_valid, mul_tag,
            div_valid, div_tag, load_valid, load_tag,
            exception, mret,
            exp_full, exp_issue_valid, exp_pc, exp_rd, exp_op, exp_src1, exp_src2);
        ok = (fields == NUM_FIELDS);
        if (!ok) begin
            $display("case %0d is malformed, read %0d of %0d fields", num + 1, fields,
                     NUM_FIELDS);
            other_errors++;
            drive_idle();
        end
    endtask

    task automatic check_outputs(input int num);
        if (full !== exp_full) begin
            $display("mismatch case %0d full: expected %h, got %h", num, exp_full, full);
            mismatch_errors++;
        end
        if (issue_valid !== exp_issue_valid) begin
            $display("mismatch case %0d issue_valid: expected %h, got %h", num,
                     exp_issue_valid, issue_valid);
            mismatch_errors++;
        end
        if (exp_issue_valid) begin  // fields only mean something on issue
            if (issue_pc !== exp_pc) begin
                $display("mismatch case %0d issue_pc: expected %h, got %h", num,
                         exp_pc, issue_pc);
                mismatch_errors++;
            end
            if (issue_rd !== exp_rd) begin
                $display("mismatch case %0d issue_rd: expected %h, got %h", num,
                         exp_rd, issue_rd);
                mismatch_errors++;
            end
            if (issue_op !== exp_op) begin
                $display("mismatch case %0d issue_op: expected %h, got %h", num,
                         exp_op, issue_op);
                mismatch_errors++;
            end
            if (issue_src1 !== exp_src1) begin
                $display("mismatch case %0d issue_src1: expected %h, got %h", num,
                         exp_src1, issue_src1);
                mismatch_errors++;
            end
            if (issue_src2 !== exp_src2) begin
                $display("mismatch case %0d issue_src2: expected %h, got %h", num,
                         exp_src2, issue_src2);
                mismatch_errors++;
            end
        end
    endtask

    initial begin
        bit loaded;
        bit ok;
        rst = 1'b1;
        drive_idle();
        load_cases(loaded);
        n_cases = case_lines.size();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (loaded) begin
            for (int i = 0; i < n_cases; i++) begin
                apply_case(i, ok);  // on the falling edge
                @(posedge clk);
                #(CLK_PERIOD/2 - 10);
                if (ok) check_outputs(i + 1);
                @(negedge clk);
            end
        end
        $display("errors: %0d (%0d mismatches, %0d other)",
                 mismatch_errors + other_errors, mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // reset plus one cycle per case, with margin
    initial begin
        wait (n_cases > 0);
        #((n_cases + 20) * CLK_PERIOD);
        $display("watchdog timeout, the run did not finish in %0d ns",
                 (n_cases + 20) * CLK_PERIOD);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: hw/div_rs.sv
`timescale 1ns/1ns

module div_rs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  div_rs_pkg::pc_t       dispatch_pc,
    input  div_rs_pkg::phys_tag_t dispatch_rd,
    input  div_rs_pkg::div_op_t   dispatch_op,
    input  div_rs_pkg::phys_tag_t dispatch_src1,
    input  div_rs_pkg::phys_tag_t dispatch_src2,
    input  logic                  dispatch_src1_ready,
    input  logic                  dispatch_src2_ready,
    input  logic                  alu_valid,
    input  div_rs_pkg::phys_tag_t alu_tag,
    input  logic                  mul_valid,
    input  div_rs_pkg::phys_tag_t mul_tag,
    input  logic                  div_valid,
    input  div_rs_pkg::phys_tag_t div_tag,
    input  logic                  load_valid,
    input  div_rs_pkg::phys_tag_t load_tag,
    input  logic                  exception,
    input  logic                  mret,
    output logic                  full,
    output logic                  issue_valid,
    output div_rs_pkg::pc_t       issue_pc,
    output div_rs_pkg::phys_tag_t issue_rd,
    output div_rs_pkg::div_op_t   issue_op,
    output div_rs_pkg::phys_tag_t issue_src1,
    output div_rs_pkg::phys_tag_t issue_src2
);
    import div_rs_pkg::*;

    logic     alloc_en;
    rs_idx_t  alloc_idx;
    rs_idx_t  head;
    rs_mask_t busy;
    rs_mask_t ready;
    logic     flush;
    logic     pick_valid;
    rs_idx_t  pick_idx;

    div_rs_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .exception      (exception),
        .mret           (mret),
        .pick_valid     (pick_valid),
        .pick_idx       (pick_idx),
        .alloc_en       (alloc_en),
        .alloc_idx      (alloc_idx),
        .head           (head),
        .busy           (busy),
        .flush          (flush),
        .full           (full)
    );

    rs_payload_store i_payload (
        .clk         (clk),
        .rst         (rst),
        .alloc_en    (alloc_en),
        .alloc_idx   (alloc_idx),
        .dispatch_pc (dispatch_pc),
        .dispatch_rd (dispatch_rd),
        .dispatch_op (dispatch_op),
        .pick_valid  (pick_valid),
        .pick_idx    (pick_idx),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd),
        .issue_op    (issue_op)
    );

    rs_wakeup i_wakeup (
        .clk                 (clk),
        .rst                 (rst),
        .flush               (flush),
        .alloc_en            (alloc_en),
        .alloc_idx           (alloc_idx),
        .dispatch_src1       (dispatch_src1),
        .dispatch_src2       (dispatch_src2),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src2_ready (dispatch_src2_ready),
        .alu_valid           (alu_valid),
        .alu_tag             (alu_tag),
        .mul_valid           (mul_valid),
        .mul_tag             (mul_tag),
        .div_valid           (div_valid),
        .div_tag             (div_tag),
        .load_valid          (load_valid),
        .load_tag            (load_tag),
        .pick_valid          (pick_valid),
        .pick_idx            (pick_idx),
        .ready               (ready),
        .issue_src1          (issue_src1),
        .issue_src2          (issue_src2)
    );

    rs_issue_select i_select (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .head        (head),
        .busy        (busy),
        .ready       (ready),
        .pick_valid  (pick_valid),
        .pick_idx    (pick_idx),
        .issue_valid (issue_valid)
    );

endmodule

// File: hw/rs_issue_select.sv
`timescale 1ns/1ns

module rs_issue_select (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  div_rs_pkg::rs_idx_t  head,
    input  div_rs_pkg::rs_mask_t busy,
    input  div_rs_pkg::rs_mask_t ready,
    output logic                 pick_valid,
    output div_rs_pkg::rs_idx_t  pick_idx,
    output logic                 issue_valid
);
    import div_rs_pkg::*;

    rs_mask_t cand;

    assign cand = busy & ready;

    // first candidate by distance from head, inside the window
    always_comb begin
        rs_idx_t idx;
        pick_valid = 1'b0;
        pick_idx   = head;
        for (int off = 0; off < SELECT_WINDOW; off++) begin
            idx = head + RS_IDX_W'(off);  // wraps mod RS_ENTRIES
            if (!pick_valid && cand[idx]) begin
                pick_valid = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= pick_valid;
        end
    end

endmodule

// File: hw/rs_wakeup.sv
`timescale 1ns/1ns

module rs_wakeup (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   alloc_en,
    input  div_rs_pkg::rs_idx_t    alloc_idx,
    input  div_rs_pkg::phys_tag_t  dispatch_src1,
    input  div_rs_pkg::phys_tag_t  dispatch_src2,
    input  logic                   dispatch_src1_ready,
    input  logic                   dispatch_src2_ready,
    input  logic                   alu_valid,
    input  div_rs_pkg::phys_tag_t  alu_tag,
    input  logic                   mul_valid,
    input  div_rs_pkg::phys_tag_t  mul_tag,
    input  logic                   div_valid,
    input  div_rs_pkg::phys_tag_t  div_tag,
    input  logic                   load_valid,
    input  div_rs_pkg::phys_tag_t  load_tag,
    input  logic                   pick_valid,
    input  div_rs_pkg::rs_idx_t    pick_idx,
    output div_rs_pkg::rs_mask_t   ready,
    output div_rs_pkg::phys_tag_t  issue_src1,
    output div_rs_pkg::phys_tag_t  issue_src2
);
    import div_rs_pkg::*;

    phys_tag_t src1_mem [RS_ENTRIES];
    phys_tag_t src2_mem [RS_ENTRIES];
    rs_mask_t  rdy1;
    rs_mask_t  rdy2;
    rs_mask_t  hit1;
    rs_mask_t  hit2;
    logic      new_rdy1;
    logic      new_rdy2;

    // tag seen on any of the four result buses this cycle
    function automatic logic bcast_hit(input phys_tag_t tag);
        return (alu_valid  && alu_tag  == tag) ||
               (mul_valid  && mul_tag  == tag) ||
               (div_valid  && div_tag  == tag) ||
               (load_valid && load_tag == tag);
    endfunction

    always_comb begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            hit1[i] = bcast_hit(src1_mem[i]);
            hit2[i] = bcast_hit(src2_mem[i]);
        end
    end

    // same-cycle broadcast counts as ready at dispatch
    assign new_rdy1 = dispatch_src1_ready | bcast_hit(dispatch_src1);
    assign new_rdy2 = dispatch_src2_ready | bcast_hit(dispatch_src2);

    assign ready = rdy1 & rdy2;

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            src1_mem[alloc_idx] <= dispatch_src1;
            src2_mem[alloc_idx] <= dispatch_src2;
        end
        if (pick_valid) begin
            issue_src1 <= src1_mem[pick_idx];
            issue_src2 <= src2_mem[pick_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdy1 <= '0;
            rdy2 <= '0;
        end else begin
            rdy1 <= rdy1 | hit1;
            rdy2 <= rdy2 | hit2;
            if (alloc_en) begin
                rdy1[alloc_idx] <= new_rdy1;  // overrides stale slot state
                rdy2[alloc_idx] <= new_rdy2;
            end
        end
    end

endmodule

// File: hw/rs_payload_store.sv
`timescale 1ns/1ns

module rs_payload_store (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_en,
    input  div_rs_pkg::rs_idx_t   alloc_idx,
    input  div_rs_pkg::pc_t       dispatch_pc,
    input  div_rs_pkg::phys_tag_t dispatch_rd,
    input  div_rs_pkg::div_op_t   dispatch_op,
    input  logic                  pick_valid,
    input  div_rs_pkg::rs_idx_t   pick_idx,
    output div_rs_pkg::pc_t       issue_pc,
    output div_rs_pkg::phys_tag_t issue_rd,
    output div_rs_pkg::div_op_t   issue_op
);
    import div_rs_pkg::*;

    pc_t       pc_mem [RS_ENTRIES];
    phys_tag_t rd_mem [RS_ENTRIES];
    div_op_t   op_mem [RS_ENTRIES];

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            pc_mem[alloc_idx] <= dispatch_pc;
            rd_mem[alloc_idx] <= dispatch_rd;
            op_mem[alloc_idx] <= dispatch_op;
        end
    end

    // issue read port, holds between picks
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_pc <= '0;
            issue_rd <= '0;
            issue_op <= '0;
        end else if (pick_valid) begin
            issue_pc <= pc_mem[pick_idx];
            issue_rd <= rd_mem[pick_idx];
            issue_op <= op_mem[pick_idx];
        end
    end

endmodule

// File: hw/div_rs_ctrl.sv
`timescale 1ns/1ns

module div_rs_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  logic                exception,
    input  logic                mret,
    input  logic                pick_valid,
    input  div_rs_pkg::rs_idx_t pick_idx,
    output logic                alloc_en,
    output div_rs_pkg::rs_idx_t alloc_idx,
    output div_rs_pkg::rs_idx_t head,
    output div_rs_pkg::rs_mask_t busy,
    output logic                flush,
    output logic                full
);
    import div_rs_pkg::*;

    rs_idx_t          tail;
    rs_mask_t         live;   // allocated, not yet passed by head
    logic [RS_IDX_W:0] count; // 0..RS_ENTRIES
    logic             retire;

    assign flush     = exception | mret;
    assign full      = (count == (RS_IDX_W+1)'(RS_ENTRIES));
    assign alloc_en  = dispatch_valid & ~full;
    assign alloc_idx = tail;

    // head moves over slots already sent to the divider
    assign retire = live[head] & ~busy[head];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            live  <= '0;
            busy  <= '0;
        end else begin
            if (pick_valid) begin
                busy[pick_idx] <= 1'b0;  // issued
            end
            if (alloc_en) begin
                live[tail] <= 1'b1;
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (retire) begin
                live[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            case ({alloc_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

// File: hw/div_rs_pkg.sv
package div_rs_pkg;

    localparam int RS_ENTRIES    = 16;
    localparam int RS_IDX_W      = 4;
    localparam int SELECT_WINDOW = 8;  // entries from head seen by the picker
    localparam int TAG_W         = 8;
    localparam int PC_W          = 32;
    localparam int OP_W          = 4;

    // physical register tag, also used on every result bus
    typedef logic [TAG_W-1:0] phys_tag_t;

    typedef logic [PC_W-1:0] pc_t;

    typedef logic [OP_W-1:0] div_op_t;

    typedef logic [RS_IDX_W-1:0] rs_idx_t;  // wraps mod RS_ENTRIES

    typedef logic [RS_ENTRIES-1:0] rs_mask_t;  // one bit per slot

endpackage
